//--- probe_sampler_top.f
source/bp_pkg.sv
source/sampler_pkg.sv
source/bp_reg.sv
source/sample_strobe.sv
source/window_accum.sv
source/pkt_fifo.sv
source/probe_sampler_top.sv
dv/tb_probe_sampler_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_probe_sampler_top
FLIST     ?= probe_sampler_top.f
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- dv/tb_probe_sampler_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_probe_sampler_top
  import bp_pkg::*, sampler_pkg::*;
;

  localparam int DEPTH = 10;
  localparam int PREC  = 32;
  localparam int TMO   = 200;   // Cycles per wait

  logic        i_clk;
  logic        i_reset;
  logic        i_cg;
  logic        i_probe;
  bp_byte_u    bp_in;
  logic        i_bp_valid;
  logic        o_bp_ready;
  logic [7:0]  o_bp_data;
  logic        o_bp_valid;
  logic        i_bp_ready;

  logic        stall_en;
  logic [31:0] lfsr_state;
  int          cyc;
  logic [7:0]  rx_q[$];       // Answer bytes
  int          rx_t[$];       // Cycle of each answer byte
  logic [31:0] words_q[$];

  logic        chk_en;
  logic        rng_en;
  logic        silent_en;
  logic [31:0] chk_got;
  logic [31:0] chk_exp;
  logic [31:0] chk_lo;
  logic [31:0] chk_hi;
  string       chk_what;

  probe_sampler_top #(
    .PKTFIFO_DEPTH (DEPTH)
  ) dut_i (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_cg       (i_cg),
    .i_probe    (i_probe),
    .i_bp_data  (bp_in),
    .i_bp_valid (i_bp_valid),
    .o_bp_ready (o_bp_ready),
    .o_bp_data  (o_bp_data),
    .o_bp_valid (o_bp_valid),
    .i_bp_ready (i_bp_ready)
  );

  always #10 i_clk = ~i_clk;

  always @(posedge i_clk) cyc <= cyc + 1;

  // Taps 32,30,26,25
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[29] ^ lfsr_state[25] ^ lfsr_state[24]};
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // One log-drop step at W = 1 with a one sampled
  function automatic logic [31:0] logdrop_step(input logic [31:0] acc);
    return acc - (acc >> 1) + (32'd1 << (PREC - 1 - 1));
  endfunction

  // Sink side with random stalls when enabled
  always @(posedge i_clk) begin
    #1;
    i_bp_ready = stall_en ? (rand_bits(1) != 0) : 1'b1;
  end

  always @(negedge i_clk) begin
    if (o_bp_valid && i_bp_ready) begin
      rx_q.push_back(o_bp_data);
      rx_t.push_back(cyc);
    end
  end

  a_value: assert property (@(posedge i_clk) chk_en |-> chk_got == chk_exp)
    else begin
      $display("mismatch at %0t: %s got %0h expected %0h", $time, chk_what, chk_got, chk_exp);
      $display("*** FAILED ***");
      $fatal(1, "value check");
    end

  a_range: assert property (@(posedge i_clk) rng_en |-> chk_got >= chk_lo && chk_got <= chk_hi)
    else begin
      $display("mismatch at %0t: %s got %0d outside %0d..%0d", $time, chk_what, chk_got,
               chk_lo, chk_hi);
      $display("*** FAILED ***");
      $fatal(1, "range check");
    end

  a_silent: assert property (@(posedge i_clk) silent_en |-> !o_bp_valid)
    else begin
      $display("mismatch at %0t: FIFO read answered while the FIFO was empty", $time);
      $display("*** FAILED ***");
      $fatal(1, "empty FIFO read");
    end

  // Input side only takes bytes while the sink takes them
  a_ready: assert property (@(posedge i_clk) o_bp_ready |-> i_bp_ready)
    else begin
      $display("mismatch at %0t: input ready high while the sink stalls", $time);
      $display("*** FAILED ***");
      $fatal(1, "ready check");
    end

  task automatic timed_out(input string what);
    $display("Timeout at %0t while waiting for %s", $time, what);
    $display("*** FAILED ***");
    $fatal(1, "timeout");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    chk_got  = got;
    chk_exp  = exp;
    chk_what = what;
    chk_en   = 1'b1;
    @(posedge i_clk);
    #1;
    chk_en = 1'b0;
  endtask

  task automatic check_range(input int val, input int lo, input int hi, input string what);
    chk_got  = val;
    chk_lo   = lo;
    chk_hi   = hi;
    chk_what = what;
    rng_en   = 1'b1;
    @(posedge i_clk);
    #1;
    rng_en = 1'b0;
  endtask

  task automatic send_byte(input logic [7:0] b);
    int  n;
    logic ok;
    n          = 0;
    ok         = 1'b0;
    bp_in.data = b;
    i_bp_valid = 1'b1;
    while (!ok) begin
      @(negedge i_clk);
      ok = o_bp_ready;
      @(posedge i_clk);
      #1;
      n++;
      if (!ok && n > TMO) timed_out("input byte accept");
    end
    i_bp_valid = 1'b0;
  endtask

  task automatic wait_bytes(input int count, input int limit, input string what);
    int n;
    n = 0;
    while (rx_q.size() < count) begin
      @(posedge i_clk);
      #1;
      n++;
      if (n > limit) timed_out(what);
    end
  endtask

  task automatic read_reg(input logic [6:0] addr, input logic [7:0] exp);
    rx_q.delete();
    send_byte({1'b0, addr});
    wait_bytes(1, TMO, "read answer");
    check_value(rx_q.pop_front(), exp, "register read");
  endtask

  task automatic write_reg(input logic [6:0] addr, input logic [7:0] data,
                           input logic [7:0] exp_old);
    rx_q.delete();
    send_byte({1'b1, addr});
    send_byte(data);
    wait_bytes(1, TMO, "write answer");
    check_value(rx_q.pop_front(), exp_old, "write old value");
  endtask

  // Burst-reads n packets and assembles them LSB first
  task automatic drain_words(input int n);
    logic [31:0] w;
    words_q.delete();
    write_reg(ADDR_BURST, 8'(4 * n), 8'd0);
    rx_q.delete();
    rx_t.delete();
    send_byte({1'b0, ADDR_PKTFIFO_RD});
    wait_bytes(4 * n, 100 * n + TMO, "FIFO burst read");
    for (int i = 0; i < n; i++) begin
      w = {rx_q[4*i+3], rx_q[4*i+2], rx_q[4*i+1], rx_q[4*i]};
      words_q.push_back(w);
    end
  endtask

  initial begin
    logic [7:0]  v[4];
    logic [31:0] acc;
    i_clk      = 1'b0;
    i_reset    = 1'b1;
    i_cg       = 1'b1;
    i_probe    = 1'b0;
    bp_in      = '0;
    i_bp_valid = 1'b0;
    i_bp_ready = 1'b0;
    stall_en   = 1'b0;
    chk_en     = 1'b0;
    rng_en     = 1'b0;
    silent_en  = 1'b0;
    cyc        = 0;
    lfsr_state = 32'hf319_b404;
    repeat (5) @(posedge i_clk);
    #1;
    i_reset = 1'b0;

    // Reset values and parameter readback
    read_reg(ADDR_PKTFIFO_DEPTH, 8'(DEPTH));
    read_reg(ADDR_MAX_WINDOW_LENGTH_EXP, 8'd32);
    read_reg(ADDR_LOGDROP_PRECISION, 8'(PREC));
    read_reg(ADDR_MAX_SAMPLE_PERIOD_EXP, 8'd32);
    read_reg(ADDR_MAX_SAMPLE_JITTER_EXP, 8'd32);
    for (int a = 9; a <= 12; a++) read_reg(7'(a), 8'd0);
    read_reg(7'd13, 8'd0);

    // RW registers answer with the old value
    for (int i = 0; i < 4; i++) begin
      v[i] = (i == 1) ? 8'(rand_bits(1)) : 8'(rand_bits(6));
      write_reg(7'(9 + i), v[i], 8'd0);
      read_reg(7'(9 + i), v[i]);
    end
    for (int i = 0; i < 4; i++) write_reg(7'(9 + i), 8'd0, v[i]);
    write_reg(ADDR_WINDOW_LENGTH_EXP, 8'h2a, 8'd0);
    stall_en = 1'b1;
    write_reg(ADDR_BURST, 8'd4, 8'd0);
    rx_q.delete();
    send_byte({1'b0, ADDR_WINDOW_LENGTH_EXP});
    wait_bytes(4, 4 * TMO, "register burst read");
    for (int i = 0; i < 4; i++) check_value(rx_q[i], 8'h2a, "burst read");
    stall_en = 1'b0;

    // Rectangular window with W = 2 and P = 2
    i_probe = 1'b1;
    write_reg(ADDR_SAMPLE_PERIOD_EXP, 8'd2, 8'd0);
    write_reg(ADDR_WINDOW_LENGTH_EXP, 8'd2, 8'h2a);
    write_reg(ADDR_PKTFIFO_FLUSH, 8'd0, 8'd0);
    drain_words(3);
    foreach (words_q[i]) check_value(words_q[i], 32'd4, "rectangular ones");
    i_probe = 1'b0;
    repeat (40) @(posedge i_clk);
    #1;
    write_reg(ADDR_PKTFIFO_FLUSH, 8'd0, 8'd0);
    drain_words(3);
    foreach (words_q[i]) check_value(words_q[i], 32'd0, "rectangular zeros");

    // Log-drop window with W = 1 and P = 3
    i_probe = 1'b1;
    write_reg(ADDR_SAMPLE_PERIOD_EXP, 8'd3, 8'd2);
    write_reg(ADDR_WINDOW_LENGTH_EXP, 8'd1, 8'd2);
    write_reg(ADDR_WINDOW_SHAPE, 8'd1, 8'd0);
    write_reg(ADDR_PKTFIFO_FLUSH, 8'd0, 8'd0);
    drain_words(4);
    // Two model steps per window from the state cleared by the shape change
    acc = 32'd0;
    foreach (words_q[i]) begin
      acc = logdrop_step(logdrop_step(acc));
      check_value(words_q[i], acc, "log-drop packet");
    end

    // Empty FIFO read stalls until a window lands
    write_reg(ADDR_WINDOW_SHAPE, 8'd0, 8'd1);
    write_reg(ADDR_SAMPLE_PERIOD_EXP, 8'd4, 8'd3);
    write_reg(ADDR_WINDOW_LENGTH_EXP, 8'd2, 8'd1);
    write_reg(ADDR_PKTFIFO_FLUSH, 8'd0, 8'd0);
    rx_q.delete();
    send_byte({1'b0, ADDR_PKTFIFO_RD});
    silent_en = 1'b1;
    repeat (30) @(posedge i_clk);
    #1;
    silent_en = 1'b0;
    wait_bytes(1, 4 * TMO, "FIFO read after a window");
    check_value(rx_q.pop_front(), 8'd4, "first byte after stall");

    // Jittered interval with W = 1, P = 2 and J = 3
    for (int i = 0; i < 4; i++) write_reg(ADDR_PRNG_SEED, 8'(rand_bits(8)), 8'd0);
    write_reg(ADDR_SAMPLE_JITTER_EXP, 8'd3, 8'd0);
    write_reg(ADDR_SAMPLE_PERIOD_EXP, 8'd2, 8'd4);
    write_reg(ADDR_WINDOW_LENGTH_EXP, 8'd1, 8'd2);
    write_reg(ADDR_PKTFIFO_FLUSH, 8'd0, 8'd0);
    drain_words(4);
    foreach (words_q[i]) check_value(words_q[i], 32'd2, "jittered window count");
    for (int k = 1; k < 4; k++) begin
      check_range(rx_t[4*k] - rx_t[4*(k-1)], 2 * 4, 2 * (4 + 7), "packet interval");
    end

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/probe_sampler_top.sv
`timescale 1ns/1ps
`default_nettype none

// Probe sampler behind a byte pipe
module probe_sampler_top
  import bp_pkg::*, sampler_pkg::*;
#(
  parameter int PKTFIFO_DEPTH         = 10,
  parameter int MAX_WINDOW_LENGTH_EXP = 32,
  parameter int LOGDROP_PRECISION     = 32,
  parameter int MAX_SAMPLE_PERIOD_EXP = 32,
  parameter int MAX_SAMPLE_JITTER_EXP = 32
) (
  input  logic       i_clk,
  input  logic       i_reset,
  input  logic       i_cg,
  input  logic       i_probe,

  input  bp_byte_u   i_bp_data,
  input  logic       i_bp_valid,
  output logic       o_bp_ready,

  output logic [7:0] o_bp_data,
  output logic       o_bp_valid,
  input  logic       i_bp_ready
);

  sampler_cfg_t        cfg;
  logic [7:0]          seed_byte;
  logic                seed_valid;
  logic [7:0]          pktfifo_data;
  logic                pktfifo_empty;
  logic                pktfifo_pop;
  logic                pktfifo_flush;
  logic                sample_valid;
  logic                sample_bit;
  logic                result_valid;
  logic [RESULT_W-1:0] result;

  bp_reg #(
    .PKTFIFO_DEPTH         (PKTFIFO_DEPTH),
    .MAX_WINDOW_LENGTH_EXP (MAX_WINDOW_LENGTH_EXP),
    .LOGDROP_PRECISION     (LOGDROP_PRECISION),
    .MAX_SAMPLE_PERIOD_EXP (MAX_SAMPLE_PERIOD_EXP),
    .MAX_SAMPLE_JITTER_EXP (MAX_SAMPLE_JITTER_EXP)
  ) u_bp_reg (
    .i_clk           (i_clk),
    .i_reset         (i_reset),
    .i_cg            (i_cg),
    .i_pktfifo_data  (pktfifo_data),
    .i_pktfifo_empty (pktfifo_empty),
    .o_pktfifo_pop   (pktfifo_pop),
    .o_pktfifo_flush (pktfifo_flush),
    .o_cfg           (cfg),
    .o_seed_byte     (seed_byte),
    .o_seed_valid    (seed_valid),
    .i_bp_data       (i_bp_data),
    .i_bp_valid      (i_bp_valid),
    .o_bp_ready      (o_bp_ready),
    .o_bp_data       (o_bp_data),
    .o_bp_valid      (o_bp_valid),
    .i_bp_ready      (i_bp_ready)
  );

  sample_strobe #(
    .MAX_SAMPLE_PERIOD_EXP (MAX_SAMPLE_PERIOD_EXP),
    .MAX_SAMPLE_JITTER_EXP (MAX_SAMPLE_JITTER_EXP)
  ) u_sample_strobe (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_cfg          (cfg),
    .i_seed_byte    (seed_byte),
    .i_seed_valid   (seed_valid),
    .i_probe        (i_probe),
    .o_sample_valid (sample_valid),
    .o_sample_bit   (sample_bit)
  );

  window_accum #(
    .MAX_WINDOW_LENGTH_EXP (MAX_WINDOW_LENGTH_EXP),
    .LOGDROP_PRECISION     (LOGDROP_PRECISION)
  ) u_window_accum (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_cfg          (cfg),
    .i_sample_valid (sample_valid),
    .i_sample_bit   (sample_bit),
    .o_result_valid (result_valid),
    .o_result       (result)
  );

  pkt_fifo #(
    .PKTFIFO_DEPTH (PKTFIFO_DEPTH)
  ) u_pkt_fifo (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_push  (result_valid),
    .i_word  (result),
    .i_pop   (pktfifo_pop),
    .i_flush (pktfifo_flush),
    .o_byte  (pktfifo_data),
    .o_empty (pktfifo_empty)
  );

endmodule

`default_nettype wire

//--- source/pkt_fifo.sv
`timescale 1ns/1ps
`default_nettype none

// Result word FIFO, drained one byte at a time
module pkt_fifo
  import sampler_pkg::*;
#(
  parameter int PKTFIFO_DEPTH = 10
) (
  input  logic                i_clk,
  input  logic                i_reset,
  input  logic                i_push,
  input  logic [RESULT_W-1:0] i_word,
  input  logic                i_pop,
  input  logic                i_flush,
  output logic [7:0]          o_byte,
  output logic                o_empty
);

  localparam int PTR_W = (PKTFIFO_DEPTH > 1) ? $clog2(PKTFIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(PKTFIFO_DEPTH + 1);

  logic [RESULT_W-1:0] mem [PKTFIFO_DEPTH];
  logic [PTR_W-1:0]    wr_ptr_q;
  logic [PTR_W-1:0]    rd_ptr_q;
  logic [CNT_W-1:0]    count_q;     // Whole packets held
  logic [1:0]          byte_idx_q;  // Byte of the head word on show
  logic                push_ok;
  logic                word_done;
  logic [RESULT_W-1:0] head_word;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(PKTFIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push_ok   = i_push && !i_flush && (count_q != CNT_W'(PKTFIFO_DEPTH)); // Drop if full
  assign word_done = i_pop && (byte_idx_q == 2'd3);
  assign head_word = mem[rd_ptr_q];
  assign o_byte    = head_word[{byte_idx_q, 3'b000} +: 8];  // LSB first
  assign o_empty   = (count_q == '0);

  always_ff @(posedge i_clk) begin
    if (i_reset || i_flush) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      byte_idx_q <= 2'd0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (i_pop) begin
        byte_idx_q <= byte_idx_q + 2'd1;
      end
      if (word_done) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q <= count_q + CNT_W'(push_ok) - CNT_W'(word_done);
    end
  end

  always_ff @(posedge i_clk) begin
    if (push_ok) begin
      mem[wr_ptr_q] <= i_word;
    end
  end

  // The register side must never pop an empty FIFO
  a_no_pop_empty: assert property (@(posedge i_clk) disable iff (i_reset)
    i_pop |-> !o_empty);

endmodule

`default_nettype wire

//--- source/window_accum.sv
`timescale 1ns/1ps
`default_nettype none

// Folds probe samples into one result per window
module window_accum
  import sampler_pkg::*;
#(
  parameter int MAX_WINDOW_LENGTH_EXP = 32,
  parameter int LOGDROP_PRECISION     = 32  // Up to RESULT_W
) (
  input  logic                i_clk,
  input  logic                i_reset,
  input  sampler_cfg_t        i_cfg,
  input  logic                i_sample_valid,
  input  logic                i_sample_bit,
  output logic                o_result_valid,
  output logic [RESULT_W-1:0] o_result
);

  logic [EXP_W-1:0]    wexp;
  logic [EXP_W-1:0]    wexp_q;
  window_shape_e       shape_q;
  logic                cfg_change;
  logic [31:0]         cnt_q;      // Strobes seen in this window
  logic [31:0]         last_cnt;
  logic                win_done;
  logic [RESULT_W-1:0] acc_q;
  logic [RESULT_W-1:0] acc_next;
  logic [RESULT_W-1:0] drop_inc;

  assign wexp = (i_cfg.window_length_exp > EXP_W'(MAX_WINDOW_LENGTH_EXP)) ?
                EXP_W'(MAX_WINDOW_LENGTH_EXP) : i_cfg.window_length_exp;

  assign cfg_change = (wexp != wexp_q) || (i_cfg.window_shape != shape_q);
  assign last_cnt   = 32'((33'd1 << wexp) - 33'd1);
  assign win_done   = i_sample_valid && !cfg_change && (cnt_q == last_cnt);

  // Weight of a one in log-drop mode
  always_comb begin
    if (int'(wexp) < LOGDROP_PRECISION) begin
      drop_inc = RESULT_W'(1) << (LOGDROP_PRECISION - 1 - int'(wexp));
    end else begin
      drop_inc = RESULT_W'(1);
    end
  end

  always_comb begin
    if (shape_q == WINDOW_SHAPE_LOGDROP) begin
      acc_next = acc_q - (acc_q >> wexp) + (i_sample_bit ? drop_inc : '0);
    end else begin
      acc_next = acc_q + RESULT_W'(i_sample_bit); // Count of ones
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      wexp_q         <= '0;
      shape_q        <= WINDOW_SHAPE_RECTANGULAR;
      cnt_q          <= 32'd0;
      acc_q          <= '0;
      o_result_valid <= 1'b0;
    end else begin
      wexp_q         <= wexp;
      shape_q        <= i_cfg.window_shape;
      o_result_valid <= win_done;
      if (cfg_change) begin
        cnt_q <= 32'd0;
        acc_q <= '0;
      end else if (i_sample_valid) begin
        cnt_q <= win_done ? 32'd0 : cnt_q + 32'd1;
        // Log-drop keeps its state across windows
        if (win_done && (shape_q == WINDOW_SHAPE_RECTANGULAR)) begin
          acc_q <= '0;
        end else begin
          acc_q <= acc_next;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (win_done) begin
      o_result <= acc_next;
    end
  end

  a_result_after_sample: assert property (@(posedge i_clk) disable iff (i_reset)
    o_result_valid |-> $past(i_sample_valid));

endmodule

`default_nettype wire

//--- source/sample_strobe.sv
`timescale 1ns/1ps
`default_nettype none

// Jittered sample timer and probe capture
module sample_strobe
  import sampler_pkg::*;
#(
  parameter int MAX_SAMPLE_PERIOD_EXP = 32,
  parameter int MAX_SAMPLE_JITTER_EXP = 32
) (
  input  logic         i_clk,
  input  logic         i_reset,
  input  sampler_cfg_t i_cfg,
  input  logic [7:0]   i_seed_byte,
  input  logic         i_seed_valid,
  input  logic         i_probe,
  output logic         o_sample_valid,
  output logic         o_sample_bit
);

  localparam logic [31:0] LFSR_INIT = 32'h0000_0001;

  sampler_cfg_t     cfg_q;
  logic [31:0]      lfsr_q;
  logic [31:0]      lfsr_shift;
  logic [31:0]      lfsr_seeded;
  logic             lfsr_fb;
  logic [32:0]      cnt_q;        // Cycles left until next strobe
  logic [EXP_W-1:0] period_exp;
  logic [EXP_W-1:0] jitter_exp;
  logic [32:0]      period;
  logic [32:0]      jitter;
  logic             cfg_change;
  logic             strobe;
  logic             probe_meta_q;
  logic             probe_sync_q;

  // Saturate at the supported maximum
  assign period_exp = (i_cfg.sample_period_exp > EXP_W'(MAX_SAMPLE_PERIOD_EXP)) ?
                      EXP_W'(MAX_SAMPLE_PERIOD_EXP) : i_cfg.sample_period_exp;
  assign jitter_exp = (i_cfg.sample_jitter_exp > EXP_W'(MAX_SAMPLE_JITTER_EXP)) ?
                      EXP_W'(MAX_SAMPLE_JITTER_EXP) : i_cfg.sample_jitter_exp;

  assign period     = 33'd1 << period_exp;
  assign jitter     = {1'b0, lfsr_q} & ((33'd1 << jitter_exp) - 33'd1);
  assign cfg_change = (i_cfg != cfg_q);
  assign strobe     = (cnt_q == 33'd0) && !cfg_change;

  // Taps 32,22,2,1
  assign lfsr_fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
  assign lfsr_shift  = {lfsr_q[23:0], i_seed_byte};
  assign lfsr_seeded = (lfsr_shift == 32'd0) ? LFSR_INIT : lfsr_shift; // Zero would lock up

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      cfg_q          <= '0;
      cnt_q          <= 33'd0;
      lfsr_q         <= LFSR_INIT;
      o_sample_valid <= 1'b0;
    end else begin
      cfg_q          <= i_cfg;
      o_sample_valid <= strobe;
      if (cfg_change) begin
        cnt_q <= period - 33'd1;            // Restart without jitter
      end else if (strobe) begin
        cnt_q <= period + jitter - 33'd1;
      end else begin
        cnt_q <= cnt_q - 33'd1;
      end
      if (i_seed_valid) begin
        lfsr_q <= lfsr_seeded;
      end else if (strobe) begin
        lfsr_q <= {lfsr_q[30:0], lfsr_fb};
      end
    end
  end

  // Two-flop synchronizer ahead of capture
  always_ff @(posedge i_clk) begin
    probe_meta_q <= i_probe;
    probe_sync_q <= probe_meta_q;
    if (strobe) begin
      o_sample_bit <= probe_sync_q;
    end
  end

  a_lfsr_nonzero: assert property (@(posedge i_clk) disable iff (i_reset)
    lfsr_q != 32'd0);

endmodule

`default_nettype wire

//--- source/bp_reg.sv
`timescale 1ns/1ps
`default_nettype none

// Byte-pipe command decoder and register map
module bp_reg
  import bp_pkg::*, sampler_pkg::*;
#(
  parameter int PKTFIFO_DEPTH         = 10, // Packets
  parameter int MAX_WINDOW_LENGTH_EXP = 32,
  parameter int LOGDROP_PRECISION     = 32,
  parameter int MAX_SAMPLE_PERIOD_EXP = 32,
  parameter int MAX_SAMPLE_JITTER_EXP = 32
) (
  input  logic         i_clk,
  input  logic         i_reset,
  input  logic         i_cg,            // Enable level

  input  logic [7:0]   i_pktfifo_data,
  input  logic         i_pktfifo_empty,
  output logic         o_pktfifo_pop,
  output logic         o_pktfifo_flush,

  output sampler_cfg_t o_cfg,

  output logic [7:0]   o_seed_byte,
  output logic         o_seed_valid,

  input  bp_byte_u     i_bp_data,
  input  logic         i_bp_valid,
  output logic         o_bp_ready,

  output logic [7:0]   o_bp_data,
  output logic         o_bp_valid,
  input  logic         i_bp_ready
);

  logic         wr_q;         // Waiting for a data byte
  logic         pend_q;       // Read answer not yet loaded
  logic [6:0]   addr_q;
  logic [7:0]   burst_q;      // Repeats left
  logic         out_valid_q;
  logic [7:0]   out_data_q;
  sampler_cfg_t cfg_q;
  logic [7:0]   rd_data;

  logic in_accepted;
  logic out_accepted;
  logic txn_begin;
  logic in_burst;
  logic last_rep;
  logic fifo_addr;
  logic fifo_stall;
  logic load_rd;
  logic load_wr;

  assign in_accepted  = i_bp_valid && o_bp_ready;
  assign out_accepted = o_bp_valid && i_bp_ready;
  assign txn_begin    = in_accepted && !wr_q;
  assign in_burst     = (burst_q != 8'd0) && (addr_q != ADDR_BURST);
  assign last_rep     = !in_burst || (burst_q == 8'd1);
  assign fifo_addr    = (addr_q == ADDR_PKTFIFO_RD);
  assign fifo_stall   = fifo_addr && i_pktfifo_empty; // Nothing to answer with yet

  // Read answer waits for a free output slot
  assign load_rd = i_cg && pend_q && !fifo_stall && (!out_valid_q || i_bp_ready);
  // Write answer carries the value before the write
  assign load_wr = in_accepted && wr_q;

  // Sink back-pressure reaches the source directly
  assign o_bp_ready = i_cg && i_bp_ready && !pend_q;
  assign o_bp_valid = i_cg && out_valid_q;
  assign o_bp_data  = out_data_q;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      wr_q        <= 1'b0;
      pend_q      <= 1'b0;
      burst_q     <= 8'd0;
      out_valid_q <= 1'b0;
    end else if (i_cg) begin
      if (txn_begin) begin
        wr_q   <= i_bp_data.cmd.wr;
        pend_q <= !i_bp_data.cmd.wr;
      end else begin
        if (load_wr && last_rep) begin
          wr_q <= 1'b0;
        end
        if (load_rd && last_rep) begin
          pend_q <= 1'b0;
        end
      end

      if (load_wr && (addr_q == ADDR_BURST)) begin
        burst_q <= i_bp_data.data;
      end else if ((load_wr || load_rd) && in_burst) begin
        burst_q <= burst_q - 8'd1;
      end

      if (load_wr || load_rd) begin
        out_valid_q <= 1'b1;
      end else if (out_accepted) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (txn_begin) begin
      addr_q <= i_bp_data.cmd.addr;
    end
    if (load_wr || load_rd) begin
      out_data_q <= rd_data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      cfg_q <= '0;
    end else if (load_wr) begin
      case (addr_q)
        ADDR_WINDOW_LENGTH_EXP: cfg_q.window_length_exp <= i_bp_data.data[EXP_W-1:0];
        ADDR_WINDOW_SHAPE:      cfg_q.window_shape      <= window_shape_e'(i_bp_data.data[0]);
        ADDR_SAMPLE_PERIOD_EXP: cfg_q.sample_period_exp <= i_bp_data.data[EXP_W-1:0];
        ADDR_SAMPLE_JITTER_EXP: cfg_q.sample_jitter_exp <= i_bp_data.data[EXP_W-1:0];
        default: ;
      endcase
    end
  end

  assign o_cfg = cfg_q;

  always_comb begin
    rd_data = 8'd0;
    if (addr_q <= ADDR_REG_HI) begin
      case (addr_q)
        ADDR_BURST:                 rd_data = burst_q;
        ADDR_PKTFIFO_RD:            rd_data = i_pktfifo_data;
        ADDR_PKTFIFO_DEPTH:         rd_data = 8'(PKTFIFO_DEPTH);
        ADDR_MAX_WINDOW_LENGTH_EXP: rd_data = 8'(MAX_WINDOW_LENGTH_EXP);
        ADDR_LOGDROP_PRECISION:     rd_data = 8'(LOGDROP_PRECISION);
        ADDR_MAX_SAMPLE_PERIOD_EXP: rd_data = 8'(MAX_SAMPLE_PERIOD_EXP);
        ADDR_MAX_SAMPLE_JITTER_EXP: rd_data = 8'(MAX_SAMPLE_JITTER_EXP);
        ADDR_WINDOW_LENGTH_EXP:     rd_data = 8'(cfg_q.window_length_exp);
        ADDR_WINDOW_SHAPE:          rd_data = 8'(cfg_q.window_shape);
        ADDR_SAMPLE_PERIOD_EXP:     rd_data = 8'(cfg_q.sample_period_exp);
        ADDR_SAMPLE_JITTER_EXP:     rd_data = 8'(cfg_q.sample_jitter_exp);
        default:                    rd_data = 8'd0; // WO locations
      endcase
    end
  end

  assign o_pktfifo_pop   = load_rd && fifo_addr;
  assign o_pktfifo_flush = load_wr && (addr_q == ADDR_PKTFIFO_FLUSH);
  assign o_seed_byte     = i_bp_data.data;
  assign o_seed_valid    = load_wr && (addr_q == ADDR_PRNG_SEED);

  // A FIFO read answer only shows up once the FIFO had a byte
  a_fifo_rd_not_empty: assert property (@(posedge i_clk) disable iff (i_reset)
    $rose(out_valid_q) && fifo_addr && !$past(wr_q) |-> !$past(i_pktfifo_empty));

  a_flush_pop_excl: assert property (@(posedge i_clk) disable iff (i_reset)
    !(o_pktfifo_flush && o_pktfifo_pop));

endmodule

`default_nettype wire

//--- source/sampler_pkg.sv
`default_nettype none

package sampler_pkg;

  localparam int RESULT_W = 32;

  // Enough for exponents up to 32
  localparam int EXP_W = 6;

  typedef enum logic [0:0] {
    WINDOW_SHAPE_RECTANGULAR = 1'b0,
    WINDOW_SHAPE_LOGDROP     = 1'b1
  } window_shape_e;

  // RW register contents as seen by the sampler
  typedef struct packed {
    logic [EXP_W-1:0] window_length_exp;
    window_shape_e    window_shape;
    logic [EXP_W-1:0] sample_period_exp;
    logic [EXP_W-1:0] sample_jitter_exp;
  } sampler_cfg_t;

endpackage

`default_nettype wire

//--- source/bp_pkg.sv
`default_nettype none

package bp_pkg;

  localparam int N_REG = 12;

  // Location 0 arms a burst for the next command
  localparam logic [6:0] ADDR_BURST                 = 7'd0;

  localparam logic [6:0] ADDR_PKTFIFO_RD            = 7'd1;  // Read pops the FIFO
  localparam logic [6:0] ADDR_PKTFIFO_FLUSH         = 7'd2;  // WO
  localparam logic [6:0] ADDR_PRNG_SEED             = 7'd3;  // WO
  localparam logic [6:0] ADDR_PKTFIFO_DEPTH         = 7'd4;  // RO
  localparam logic [6:0] ADDR_MAX_WINDOW_LENGTH_EXP = 7'd5;  // RO
  localparam logic [6:0] ADDR_LOGDROP_PRECISION     = 7'd6;  // RO
  localparam logic [6:0] ADDR_MAX_SAMPLE_PERIOD_EXP = 7'd7;  // RO
  localparam logic [6:0] ADDR_MAX_SAMPLE_JITTER_EXP = 7'd8;  // RO
  localparam logic [6:0] ADDR_WINDOW_LENGTH_EXP     = 7'd9;  // RW
  localparam logic [6:0] ADDR_WINDOW_SHAPE          = 7'd10; // RW
  localparam logic [6:0] ADDR_SAMPLE_PERIOD_EXP     = 7'd11; // RW
  localparam logic [6:0] ADDR_SAMPLE_JITTER_EXP     = 7'd12; // RW

  // Highest mapped address, anything above reads as zero
  localparam logic [6:0] ADDR_REG_HI = 7'(N_REG);

  typedef struct packed {
    logic       wr;   // 1 for write, 0 for read
    logic [6:0] addr;
  } bp_cmd_t;

  // A pipe byte is either a command or a data byte
  typedef union packed {
    bp_cmd_t    cmd;
    logic [7:0] data;
  } bp_byte_u;

endpackage

`default_nettype wire
